//--- Makefile
SIM       := verilator
SIM_FLAGS := --binary --timing --assert -Wno-fatal
TOP       := tb_vrf_interface
FILE_LIST := tb.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILE_LIST))

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILE_LIST)
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILE_LIST)

run: $(BIN)
	-./$(BIN) +verilator+error+limit+1000 > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Simulation FAILED" $(LOG); then exit 1; fi
	@grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- design/vrf_cfg_pkg.sv
package vrf_cfg_pkg;

  // Element and memory bus width
  parameter int unsigned ELEN_DEFAULT = 32;
  // Vector register length in bits
  parameter int unsigned VLEN_DEFAULT = 128;

  // Largest count is 32 elements (VLEN 128, ELEN 32, m8)
  parameter int unsigned CountWidth = 8;

  // Register group multiplier, signed code
  typedef enum logic signed [2:0] {
    mf8 = -3,
    mf4 = -2,
    mf2 = -1,
    m1  = 0,
    m2  = 1,
    m4  = 2,
    m8  = 3
  } vlmul_e;

  // Elements in one vector register
  function automatic int unsigned base_count(int unsigned vlen, int unsigned elen);
    return vlen / elen;
  endfunction

  // Fractional LMUL shifts right, grouped LMUL shifts left
  function automatic logic [CountWidth-1:0] elem_count(int unsigned base, vlmul_e lmul);
    int          shamt;
    int unsigned count;
    shamt = $signed(lmul);
    if (shamt < 0) begin
      count = base >> (-shamt);
    end else begin
      count = base << shamt;
    end
    return count[CountWidth-1:0];
  endfunction

endpackage

//--- design/vrf_ctrl_pkg.sv
package vrf_ctrl_pkg;

  // Steps selected for one element, rd_rs1 sits in bit 0
  typedef struct packed {
    logic wr_rd;
    logic rd_rs2;
    logic rd_rs1;
  } op_sel_t;

  // Sequencer states
  typedef enum logic [2:0] {
    IDLE,
    START,
    READ1,
    READ2,
    WRITE,
    LOAD,
    LOAD_WAITGNT,
    LOAD_WRITE
  } vrf_state_e;

  // Register file access issued in a cycle
  typedef enum logic [1:0] {
    STEP_NONE,
    STEP_RS1,
    STEP_RS2,
    STEP_RD
  } step_e;

  // Next selected step after the one just granted, STEP_NONE starts an element
  function automatic step_e next_step(op_sel_t sel, step_e after);
    if (after == STEP_NONE && sel.rd_rs1) return STEP_RS1;
    if ((after == STEP_NONE || after == STEP_RS1) && sel.rd_rs2) return STEP_RS2;
    if (after != STEP_RD && sel.wr_rd) return STEP_RD;
    return STEP_NONE;
  endfunction

endpackage

//--- design/vrf_interface.sv
module vrf_interface import vrf_cfg_pkg::*, vrf_ctrl_pkg::*; #(
  parameter int unsigned VLen      = VLEN_DEFAULT,
  parameter int unsigned ElemWidth = ELEN_DEFAULT
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,

  // Vector unit
  input  logic                   req_i,
  input  logic                   memory_op_i,
  input  op_sel_t                sel_operation_i,
  input  vlmul_e                 lmul_i,
  input  logic [ElemWidth-1:0]   wdata_i,
  output logic [ElemWidth-1:0]   rdata_a_o,
  output logic [ElemWidth-1:0]   rdata_b_o,
  output logic                   vector_done_o,

  // Data memory
  output logic                   data_req_o,
  input  logic                   data_gnt_i,
  input  logic                   data_rvalid_i,
  output logic                   data_we_o,
  output logic [ElemWidth/8-1:0] data_be_o,
  output logic [ElemWidth-1:0]   data_wdata_o,
  input  logic [ElemWidth-1:0]   data_rdata_i,
  output logic                   data_load_addr_o,

  // Address unit
  output logic                   agu_load_o,
  output logic                   agu_get_rs1_o,
  output logic                   agu_get_rs2_o,
  output logic                   agu_get_rd_o,
  output logic                   agu_incr_o,

  // LSU
  output logic                   lsu_req_o,
  input  logic                   lsu_done_i
);

  // Whole words only
  localparam logic [ElemWidth/8-1:0] FixedBe = '1;

  logic cnt_load;
  logic cnt_dec;
  logic cnt_last;
  logic issue_rs1;
  logic issue_rs2;

  //////////////////////////////
  // Sequencer
  //////////////////////////////

  vrf_seq_fsm i_seq_fsm (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .req_i            (req_i),
    .memory_op_i      (memory_op_i),
    .sel_operation_i  (sel_operation_i),
    .data_gnt_i       (data_gnt_i),
    .lsu_done_i       (lsu_done_i),
    .last_i           (cnt_last),
    .load_o           (cnt_load),
    .dec_o            (cnt_dec),
    .issue_rs1_o      (issue_rs1),
    .issue_rs2_o      (issue_rs2),
    .data_req_o       (data_req_o),
    .data_we_o        (data_we_o),
    .data_load_addr_o (data_load_addr_o),
    .agu_load_o       (agu_load_o),
    .agu_get_rs1_o    (agu_get_rs1_o),
    .agu_get_rs2_o    (agu_get_rs2_o),
    .agu_get_rd_o     (agu_get_rd_o),
    .agu_incr_o       (agu_incr_o),
    .lsu_req_o        (lsu_req_o),
    .vector_done_o    (vector_done_o)
  );

  vrf_iter_counter #(
    .VLen      (VLen),
    .ElemWidth (ElemWidth)
  ) i_iter_counter (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .load_i (cnt_load),
    .dec_i  (cnt_dec),
    .lmul_i (lmul_i),
    .last_o (cnt_last)
  );

  //////////////////////////////
  // Operands and write data
  //////////////////////////////

  vrf_operand_latch #(
    .ElemWidth (ElemWidth)
  ) i_operand_latch (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .issue_rs1_i   (issue_rs1),
    .issue_rs2_i   (issue_rs2),
    .data_rvalid_i (data_rvalid_i),
    .data_rdata_i  (data_rdata_i),
    .rdata_a_o     (rdata_a_o),
    .rdata_b_o     (rdata_b_o)
  );

  assign data_be_o    = FixedBe;
  assign data_wdata_o = wdata_i;

endmodule

//--- design/vrf_iter_counter.sv
module vrf_iter_counter import vrf_cfg_pkg::*; #(
  parameter int unsigned VLen      = VLEN_DEFAULT,
  parameter int unsigned ElemWidth = ELEN_DEFAULT
) (
  input  logic   clk_i,
  input  logic   rst_ni,

  // Sequencer control
  input  logic   load_i,
  input  logic   dec_i,
  input  vlmul_e lmul_i,

  // Final element flag
  output logic   last_o
);

  // Elements per register at LMUL 1
  localparam int unsigned BaseCount = base_count(VLen, ElemWidth);

  logic [CountWidth-1:0] count_q;
  logic [CountWidth-1:0] count_d;

  always_comb begin
    count_d = count_q;
    if (load_i) begin
      count_d = elem_count(BaseCount, lmul_i);
    end else if (dec_i) begin
      count_d = count_q - 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      count_q <= '0;
    end else begin
      count_q <= count_d;
    end
  end

  // One element left
  assign last_o = (count_q == CountWidth'(1));

endmodule

//--- design/vrf_operand_latch.sv
module vrf_operand_latch #(
  parameter int unsigned ElemWidth = 32
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,

  // Granted operand reads
  input  logic                 issue_rs1_i,
  input  logic                 issue_rs2_i,

  // Memory response
  input  logic                 data_rvalid_i,
  input  logic [ElemWidth-1:0] data_rdata_i,

  // Captured operands
  output logic [ElemWidth-1:0] rdata_a_o,
  output logic [ElemWidth-1:0] rdata_b_o
);

  logic                 pending_q;
  logic                 target_b_q;
  logic [ElemWidth-1:0] rs1_q;
  logic [ElemWidth-1:0] rs2_q;

  // Response of the previous grant arrives with the next grant at the earliest
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pending_q  <= 1'b0;
      target_b_q <= 1'b0;
    end else if (issue_rs1_i || issue_rs2_i) begin
      pending_q  <= 1'b1;
      target_b_q <= issue_rs2_i;
    end else if (data_rvalid_i) begin
      pending_q  <= 1'b0;
    end
  end

  // Write responses leave the operands untouched
  always_ff @(posedge clk_i) begin
    if (data_rvalid_i && pending_q) begin
      if (target_b_q) begin
        rs2_q <= data_rdata_i;
      end else begin
        rs1_q <= data_rdata_i;
      end
    end
  end

  assign rdata_a_o = rs1_q;
  assign rdata_b_o = rs2_q;

endmodule

//--- design/vrf_seq_fsm.sv
module vrf_seq_fsm import vrf_ctrl_pkg::*; (
  input  logic    clk_i,
  input  logic    rst_ni,

  // Operation request
  input  logic    req_i,
  input  logic    memory_op_i,
  input  op_sel_t sel_operation_i,

  // Memory and LSU status
  input  logic    data_gnt_i,
  input  logic    lsu_done_i,

  // Element counter
  input  logic    last_i,
  output logic    load_o,
  output logic    dec_o,

  // Operand latch
  output logic    issue_rs1_o,
  output logic    issue_rs2_o,

  // Data memory
  output logic    data_req_o,
  output logic    data_we_o,
  output logic    data_load_addr_o,

  // Address unit
  output logic    agu_load_o,
  output logic    agu_get_rs1_o,
  output logic    agu_get_rs2_o,
  output logic    agu_get_rd_o,
  output logic    agu_incr_o,

  // LSU and pipeline
  output logic    lsu_req_o,
  output logic    vector_done_o
);

  vrf_state_e state_q, state_d;
  op_sel_t    sel_q, sel_d;
  logic       mem_q, mem_d;

  // Step issued this cycle and whether an arithmetic element closes
  step_e step;
  logic  elem_end;

  // State that follows a granted arithmetic step
  function automatic vrf_state_e step_state(step_e s);
    case (s)
      STEP_RS1: return READ1;
      STEP_RS2: return READ2;
      default:  return WRITE;
    endcase
  endfunction

  //////////////////////////////
  // Next state
  //////////////////////////////

  always_comb begin
    state_d          = state_q;
    sel_d            = sel_q;
    mem_d            = mem_q;
    step             = STEP_NONE;
    elem_end         = 1'b0;
    load_o           = 1'b0;
    dec_o            = 1'b0;
    issue_rs1_o      = 1'b0;
    issue_rs2_o      = 1'b0;
    data_req_o       = 1'b0;
    data_we_o        = 1'b0;
    data_load_addr_o = 1'b0;
    agu_load_o       = 1'b0;
    agu_get_rs1_o    = 1'b0;
    agu_get_rs2_o    = 1'b0;
    agu_get_rd_o     = 1'b0;
    agu_incr_o       = 1'b0;
    lsu_req_o        = 1'b0;
    vector_done_o    = 1'b0;

    case (state_q)
      IDLE: begin
        if (req_i) begin
          agu_load_o       = 1'b1;
          load_o           = 1'b1;
          data_load_addr_o = memory_op_i;
          sel_d            = sel_operation_i;
          mem_d            = memory_op_i;
          state_d          = START;
        end
      end

      START: begin
        if (mem_q) begin
          // Loads hand the first element to the LSU
          if (sel_q.wr_rd) begin
            lsu_req_o = 1'b1;
            state_d   = LOAD;
          end else begin
            state_d = IDLE;
          end
        end else begin
          step = next_step(sel_q, STEP_NONE);
          if (step == STEP_NONE) begin
            state_d = IDLE;
          end
        end
      end

      READ1: begin
        step     = next_step(sel_q, STEP_RS1);
        elem_end = (step == STEP_NONE);
      end

      READ2: begin
        step     = next_step(sel_q, STEP_RS2);
        elem_end = (step == STEP_NONE);
      end

      WRITE: begin
        elem_end = 1'b1;
      end

      LOAD: begin
        if (lsu_done_i) begin
          step = STEP_RD;
        end
      end

      LOAD_WAITGNT: begin
        step = STEP_RD;
      end

      LOAD_WRITE: begin
        if (last_i) begin
          vector_done_o = 1'b1;
          state_d       = IDLE;
        end else begin
          dec_o     = 1'b1;
          lsu_req_o = 1'b1;
          state_d   = LOAD;
        end
      end

      default: begin
        state_d = IDLE;
      end
    endcase

    // Close the element, the next one starts only once its first step is granted
    if (elem_end) begin
      if (last_i) begin
        vector_done_o = 1'b1;
        state_d       = IDLE;
      end else begin
        step  = next_step(sel_q, STEP_NONE);
        dec_o = data_gnt_i;
      end
    end

    //////////////////////////////
    // Register file access
    //////////////////////////////

    if (step != STEP_NONE) begin
      data_req_o    = 1'b1;
      data_we_o     = (step == STEP_RD);
      agu_get_rs1_o = (step == STEP_RS1);
      agu_get_rs2_o = (step == STEP_RS2);
      agu_get_rd_o  = (step == STEP_RD);
      if (data_gnt_i) begin
        agu_incr_o  = 1'b1;
        issue_rs1_o = (step == STEP_RS1);
        issue_rs2_o = (step == STEP_RS2);
        state_d     = mem_q ? LOAD_WRITE : step_state(step);
      end else if (state_q == LOAD) begin
        state_d = LOAD_WAITGNT;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      sel_q   <= '0;
      mem_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      sel_q   <= sel_d;
      mem_q   <= mem_d;
    end
  end

endmodule

//--- tb.f
design/vrf_cfg_pkg.sv
design/vrf_ctrl_pkg.sv
design/vrf_iter_counter.sv
design/vrf_operand_latch.sv
design/vrf_seq_fsm.sv
design/vrf_interface.sv
testbench/vrf_interface_chk.sv
testbench/tb_vrf_interface.sv

//--- testbench/tb_vrf_interface.sv
module tb_vrf_interface import vrf_cfg_pkg::*, vrf_ctrl_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned VLen      = 128;
  localparam int unsigned ElemWidth = 32;
  localparam int          WaitLimit = 400;

  logic                   clk_i         = 1'b0;
  logic                   rst_ni;
  logic                   req_i;
  logic                   memory_op_i;
  op_sel_t                sel_operation_i;
  vlmul_e                 lmul_i;
  logic [ElemWidth-1:0]   wdata_i;
  logic                   data_gnt_i    = 1'b0;
  logic                   data_rvalid_i = 1'b0;
  logic [ElemWidth-1:0]   data_rdata_i  = '0;
  logic                   lsu_done_i    = 1'b0;
  logic [ElemWidth-1:0]   rdata_a_o;
  logic [ElemWidth-1:0]   rdata_b_o;
  logic                   vector_done_o;
  logic                   data_req_o;
  logic                   data_we_o;
  logic [ElemWidth/8-1:0] data_be_o;
  logic [ElemWidth-1:0]   data_wdata_o;
  logic                   data_load_addr_o;
  logic                   agu_load_o;
  logic                   agu_get_rs1_o;
  logic                   agu_get_rs2_o;
  logic                   agu_get_rd_o;
  logic                   agu_incr_o;
  logic                   lsu_req_o;

  int   error_count   = 0;
  int   timeout_count = 0;
  logic aborted       = 1'b0;
  logic read_granted  = 1'b0;
  int   lsu_delay     = 0;

  vrf_interface #(
    .VLen      (VLen),
    .ElemWidth (ElemWidth)
  ) i_dut (.*);

  always #50 clk_i = ~clk_i;

  //////////////////////////////
  // Responders
  //////////////////////////////

  // Memory: random grant, running data word one cycle after a granted read
  always @(posedge clk_i) begin
    read_granted <= data_req_o && data_gnt_i && !data_we_o;
  end

  always @(negedge clk_i) begin
    data_gnt_i    <= ($urandom_range(2) != 0);
    data_rvalid_i <= read_granted;
    if (read_granted) begin
      data_rdata_i <= data_rdata_i + ElemWidth'(1);
    end
  end

  // LSU answers one to four cycles after its request
  always @(posedge clk_i) begin
    if (lsu_req_o) begin
      lsu_delay <= 1 + int'($urandom_range(3));
    end else if (lsu_delay > 0) begin
      lsu_delay <= lsu_delay - 1;
    end
  end

  always @(negedge clk_i) begin
    lsu_done_i <= (lsu_delay == 1);
  end

  // Elements per operation for the given register group
  function automatic int writes_for(vlmul_e lmul);
    int per_reg;
    per_reg = int'(VLen / ElemWidth);
    case (lmul)
      mf8:     return per_reg / 8;
      mf4:     return per_reg / 4;
      mf2:     return per_reg / 2;
      m2:      return per_reg * 2;
      m4:      return per_reg * 4;
      m8:      return per_reg * 8;
      default: return per_reg;
    endcase
  endfunction

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  task automatic send_request(input logic mem, input op_sel_t sel, input vlmul_e lmul);
    @(negedge clk_i);
    req_i           = 1'b1;
    memory_op_i     = mem;
    sel_operation_i = sel;
    lmul_i          = lmul;
    wdata_i         = $urandom;
    @(negedge clk_i);
    req_i = 1'b0;
  endtask

  task automatic run_op(input logic mem, input op_sel_t sel, input vlmul_e lmul);
    int   cycles;
    int   writes;
    logic done;
    if (aborted) return;
    send_request(mem, sel, lmul);
    cycles = 0;
    writes = 0;
    done   = 1'b0;
    while (!done && cycles < WaitLimit) begin
      @(posedge clk_i);
      cycles++;
      if (data_req_o && data_gnt_i && data_we_o) begin
        writes++;
      end
      done = vector_done_o;
    end
    if (!done) begin
      timeout_count++;
      aborted = 1'b1;
      $display("Timeout: no vector_done_o within %0d cycles (lmul %s)", WaitLimit, lmul.name());
    end else if (writes != writes_for(lmul)) begin
      error_count++;
      $display("[FAIL] %0t granted writes (data_we_o) for lmul %s: expected %0d, got %0d",
               $time, lmul.name(), writes_for(lmul), writes);
    end
  endtask

  // Nothing selected, so the request must die quietly
  task automatic run_empty();
    int   cycles;
    logic active;
    if (aborted) return;
    send_request(1'b0, op_sel_t'(3'b000), m1);
    active = 1'b0;
    for (cycles = 0; cycles < 8; cycles++) begin
      @(posedge clk_i);
      active = active || vector_done_o || data_req_o;
    end
    if (active) begin
      error_count++;
      $display("Empty selection raised vector_done_o or data_req_o before %0t", $time);
    end
  endtask

  task automatic report_end();
    int assert_errors;
    assert_errors = i_dut.i_chk.fail_count;
    $display("Errors: %0d checks, %0d assertions, %0d timeouts",
             error_count, assert_errors, timeout_count);
    if (error_count == 0 && assert_errors == 0 && timeout_count == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  endtask

  initial begin
    void'($urandom(32'h17ee));
    rst_ni          = 1'b0;
    req_i           = 1'b0;
    memory_op_i     = 1'b0;
    sel_operation_i = '0;
    lmul_i          = m1;
    wdata_i         = '0;
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;

    // Read rs1, read rs2, write rd
    run_op(1'b0, op_sel_t'(3'b111), m1);
    run_op(1'b0, op_sel_t'(3'b111), m2);
    run_op(1'b0, op_sel_t'(3'b111), mf2);
    run_op(1'b0, op_sel_t'(3'b100), m1);
    // Load through the LSU
    run_op(1'b1, op_sel_t'(3'b100), m1);
    run_empty();
    report_end();
  end

endmodule

//--- testbench/vrf_interface_chk.sv
module vrf_interface_chk #(
  parameter int unsigned ElemWidth = 32
) (
  input logic                   clk_i,
  input logic                   rst_ni,
  input logic                   req_i,
  input logic                   memory_op_i,
  input logic [ElemWidth-1:0]   wdata_i,
  input logic [ElemWidth-1:0]   rdata_a_o,
  input logic [ElemWidth-1:0]   rdata_b_o,
  input logic                   vector_done_o,
  input logic                   data_req_o,
  input logic                   data_gnt_i,
  input logic                   data_we_o,
  input logic [ElemWidth/8-1:0] data_be_o,
  input logic [ElemWidth-1:0]   data_wdata_o,
  input logic [ElemWidth-1:0]   data_rdata_i,
  input logic                   data_load_addr_o,
  input logic                   agu_load_o,
  input logic                   agu_get_rs1_o,
  input logic                   agu_get_rs2_o,
  input logic                   agu_get_rd_o,
  input logic                   agu_incr_o,
  input logic                   lsu_req_o,
  input logic                   lsu_done_i
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam logic [ElemWidth/8-1:0] AllBytes = '1;

  int unsigned fail_count = 0;

  logic                 granted;
  logic                 accept;
  logic [3:0]           req_vec;
  logic [3:0]           req_vec_q;
  logic                 stall_q;
  logic [1:0]           rs1_pipe_q;
  logic [1:0]           rs2_pipe_q;
  logic [ElemWidth-1:0] rdata_q;
  logic                 done_q;
  logic                 load_op_q;
  logic                 lsu_seen_q;
  logic                 idle_q;
  logic                 start_q;

  assign granted = data_req_o && data_gnt_i;
  assign accept  = req_i && idle_q;
  assign req_vec = {data_we_o, agu_get_rs1_o, agu_get_rs2_o, agu_get_rd_o};

  // Short history of the bus, looked at one or two cycles later
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_vec_q  <= '0;
      stall_q    <= 1'b0;
      rs1_pipe_q <= '0;
      rs2_pipe_q <= '0;
      rdata_q    <= '0;
      done_q     <= 1'b0;
      load_op_q  <= 1'b0;
      lsu_seen_q <= 1'b0;
      idle_q     <= 1'b1;
      start_q    <= 1'b0;
    end else begin
      req_vec_q  <= req_vec;
      stall_q    <= data_req_o && !data_gnt_i;
      rs1_pipe_q <= {rs1_pipe_q[0], granted && agu_get_rs1_o};
      rs2_pipe_q <= {rs2_pipe_q[0], granted && agu_get_rs2_o};
      rdata_q    <= data_rdata_i;
      done_q     <= vector_done_o;
      if (agu_load_o) begin
        load_op_q <= memory_op_i;
      end
      // Cleared by the write that consumes the LSU result
      lsu_seen_q <= (lsu_seen_q || lsu_done_i) && !(granted && data_we_o);
      // Sequencer idle as seen on the ports, an empty start issues nothing
      start_q <= accept;
      if (accept) begin
        idle_q <= 1'b0;
      end else if (vector_done_o || (start_q && !data_req_o && !lsu_req_o)) begin
        idle_q <= 1'b1;
      end
    end
  end

  //////////////////////////////
  // Assertions
  //////////////////////////////

  a_reset_quiet: assert property (@(posedge clk_i)
    (!rst_ni || !$past(rst_ni)) |-> !(data_req_o || lsu_req_o || agu_incr_o || vector_done_o))
    else begin
      fail_count++;
      $error("[FAIL] %0t {data_req_o,lsu_req_o,agu_incr_o,vector_done_o}: expected 0000, got %b",
             $time, $sampled({data_req_o, lsu_req_o, agu_incr_o, vector_done_o}));
    end

  a_agu_load: assert property (@(posedge clk_i) disable iff (!rst_ni)
    agu_load_o == accept)
    else begin
      fail_count++;
      $error("[FAIL] %0t agu_load_o: expected %b, got %b", $time,
             $sampled(accept), $sampled(agu_load_o));
    end

  a_load_addr: assert property (@(posedge clk_i) disable iff (!rst_ni)
    data_load_addr_o == (accept && memory_op_i))
    else begin
      fail_count++;
      $error("[FAIL] %0t data_load_addr_o: expected %b, got %b", $time,
             $sampled(accept && memory_op_i), $sampled(data_load_addr_o));
    end

  a_incr: assert property (@(posedge clk_i) disable iff (!rst_ni)
    agu_incr_o == granted)
    else begin
      fail_count++;
      $error("[FAIL] %0t agu_incr_o: expected %b, got %b", $time,
             $sampled(granted), $sampled(agu_incr_o));
    end

  a_hold_on_stall: assert property (@(posedge clk_i) disable iff (!rst_ni)
    stall_q |-> data_req_o && (req_vec == req_vec_q))
    else begin
      fail_count++;
      $error("[FAIL] %0t {data_req_o,data_we_o,agu_get_*}: expected %b, got %b", $time,
             $sampled({1'b1, req_vec_q}), $sampled({data_req_o, req_vec}));
    end

  a_rs1_capture: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rs1_pipe_q[1] |-> rdata_a_o == rdata_q)
    else begin
      fail_count++;
      $error("[FAIL] %0t rdata_a_o: expected %h, got %h", $time,
             $sampled(rdata_q), $sampled(rdata_a_o));
    end

  a_rs2_capture: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rs2_pipe_q[1] |-> rdata_b_o == rdata_q)
    else begin
      fail_count++;
      $error("[FAIL] %0t rdata_b_o: expected %h, got %h", $time,
             $sampled(rdata_q), $sampled(rdata_b_o));
    end

  // Loads only ever write the destination
  a_load_write: assert property (@(posedge clk_i) disable iff (!rst_ni)
    load_op_q && granted |-> data_we_o && agu_get_rd_o)
    else begin
      fail_count++;
      $error("[FAIL] %0t {data_we_o,agu_get_rd_o}: expected 11, got %b", $time,
             $sampled({data_we_o, agu_get_rd_o}));
    end

  a_load_after_lsu: assert property (@(posedge clk_i) disable iff (!rst_ni)
    load_op_q && granted |-> lsu_seen_q || lsu_done_i)
    else begin
      fail_count++;
      $error("Load write granted at %0t without a preceding lsu_done_i", $time);
    end

  a_write_data: assert property (@(posedge clk_i) disable iff (!rst_ni)
    granted && data_we_o |-> {data_be_o, data_wdata_o} == {AllBytes, wdata_i})
    else begin
      fail_count++;
      $error("[FAIL] %0t {data_be_o,data_wdata_o}: expected %h, got %h", $time,
             $sampled({AllBytes, wdata_i}), $sampled({data_be_o, data_wdata_o}));
    end

  a_done_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    done_q |-> !vector_done_o && !data_req_o)
    else begin
      fail_count++;
      $error("[FAIL] %0t {vector_done_o,data_req_o}: expected 00, got %b", $time,
             $sampled({vector_done_o, data_req_o}));
    end

endmodule

bind vrf_interface vrf_interface_chk #(
  .ElemWidth (ElemWidth)
) i_chk (.*);
